// File: mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define DATA_W 32
`define REG_W  5

// primary opcodes.
`define OP_SPECIAL 6'b000000
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_ADDIU   6'b001001
`define OP_SLTI    6'b001010
`define OP_SLTIU   6'b001011
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111

// function codes under OP_SPECIAL.
`define FN_SLL  6'b000000
`define FN_SRL  6'b000010
`define FN_SRA  6'b000011
`define FN_SLLV 6'b000100
`define FN_SRLV 6'b000110
`define FN_SRAV 6'b000111
`define FN_MFHI 6'b010000
`define FN_MFLO 6'b010010
`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_NOR  6'b100111
`define FN_SLT  6'b101010
`define FN_SLTU 6'b101011

`endif

// File: mips_pkg.sv
`include "mips_defines.svh"

package mips_pkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`REG_W-1:0]  reg_idx_t;
    typedef logic [31:0]        instr_t;
    typedef logic [15:0]        imm_t;
    typedef logic [4:0]         shamt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // operand b comes from rt or from the immediate.
    typedef enum logic [1:0] {
        SRC_B_RT,
        SRC_B_SIGN,
        SRC_B_ZERO
    } src_b_e;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_HI,
        RES_LO
    } res_src_e;

endpackage

// File: alu.sv
`timescale 1ns/1ps

module alu import mips_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  shamt_t  sa,
    input  alu_op_e op,
    output word_t   y,
    output logic    zero
);

    always_comb begin
        case (op)
            ALU_ADD:
                y = a + b;
            ALU_SUB:
                y = a - b;
            ALU_AND:
                y = a & b;
            ALU_OR:
                y = a | b;
            ALU_XOR:
                y = a ^ b;
            ALU_NOR:
                y = ~(a | b);
            ALU_SLT:
                y = word_t'($signed(a) < $signed(b));
            ALU_SLTU:
                y = word_t'(a < b);
            // shifts work on operand b, as mips does with rt.
            ALU_SLL:
                y = b << sa;
            ALU_SRL:
                y = b >> sa;
            ALU_SRA:
                y = word_t'($signed(b) >>> sa);
            ALU_LUI:
                y = {b[15:0], 16'h0000};
            default:
                y = '0;
        endcase
    end

    // branch compare runs as a subtract.
    assign zero = (y == '0);

endmodule

// File: instr_decode.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module instr_decode import mips_pkg::*; (
    input  instr_t   instr,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    output reg_idx_t rd_idx,
    output imm_t     imm,
    output shamt_t   shamt,
    output alu_op_e  alu_op,
    output src_b_e   src_b,
    output res_src_e res_src,
    output logic     var_shift,
    output logic     writes,
    output logic     dest_rd,
    output logic     is_beq,
    output logic     is_bne
);

    logic [5:0] op;
    logic [5:0] funct;

    assign op     = instr[31:26];
    assign rs_idx = instr[25:21];
    assign rt_idx = instr[20:16];
    assign rd_idx = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    always_comb begin
        alu_op    = ALU_ADD;
        src_b     = SRC_B_RT;
        res_src   = RES_ALU;
        var_shift = 1'b0;
        writes    = 1'b1;
        dest_rd   = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        case (op)
            `OP_SPECIAL: begin
                dest_rd   = 1'b1;
                var_shift = (funct == `FN_SLLV) || (funct == `FN_SRLV) || (funct == `FN_SRAV);
                case (funct)
                    `FN_ADDU: alu_op = ALU_ADD;
                    `FN_SUBU: alu_op = ALU_SUB;
                    `FN_AND:  alu_op = ALU_AND;
                    `FN_OR:   alu_op = ALU_OR;
                    `FN_XOR:  alu_op = ALU_XOR;
                    `FN_NOR:  alu_op = ALU_NOR;
                    `FN_SLT:  alu_op = ALU_SLT;
                    `FN_SLTU: alu_op = ALU_SLTU;
                    `FN_SLL, `FN_SLLV: alu_op = ALU_SLL;
                    `FN_SRL, `FN_SRLV: alu_op = ALU_SRL;
                    `FN_SRA, `FN_SRAV: alu_op = ALU_SRA;
                    `FN_MFHI: res_src = RES_HI;
                    `FN_MFLO: res_src = RES_LO;
                    default:  writes = 1'b0;
                endcase
            end
            `OP_ADDIU:
                src_b = SRC_B_SIGN;
            `OP_SLTI: begin
                alu_op = ALU_SLT;
                src_b  = SRC_B_SIGN;
            end
            `OP_SLTIU: begin
                alu_op = ALU_SLTU;
                src_b  = SRC_B_SIGN;
            end
            // logic immediates are zero extended.
            `OP_ANDI: begin
                alu_op = ALU_AND;
                src_b  = SRC_B_ZERO;
            end
            `OP_ORI: begin
                alu_op = ALU_OR;
                src_b  = SRC_B_ZERO;
            end
            `OP_XORI: begin
                alu_op = ALU_XOR;
                src_b  = SRC_B_ZERO;
            end
            `OP_LUI: begin
                alu_op = ALU_LUI;
                src_b  = SRC_B_ZERO;
            end
            `OP_BEQ: begin
                alu_op = ALU_SUB;
                writes = 1'b0;
                is_beq = 1'b1;
            end
            `OP_BNE: begin
                alu_op = ALU_SUB;
                writes = 1'b0;
                is_bne = 1'b1;
            end
            default:
                writes = 1'b0;
        endcase
    end

endmodule

// File: pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic             d_valid,
    input  logic [WIDTH-1:0] d,
    output logic             q_valid,
    output logic [WIDTH-1:0] q
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else if (!stall) begin
            q_valid <= d_valid;
        end
    end

    // payload only.
    always_ff @(posedge clk) begin
        if (!stall) begin
            q <= d;
        end
    end

endmodule

// File: forward_unit.sv
`timescale 1ns/1ps

module forward_unit import mips_pkg::*; (
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  word_t    rs_val,
    input  word_t    rt_val,
    input  logic     mem_valid,
    input  logic     mem_write,
    input  reg_idx_t mem_reg,
    input  word_t    mem_data,
    input  logic     wb_write,
    input  reg_idx_t wb_reg,
    input  word_t    wb_data,
    output word_t    rs_fwd,
    output word_t    rt_fwd
);

    // newest producer wins; r0 always reads the file value.
    function automatic word_t pick(input reg_idx_t idx, input word_t rf_val);
        logic hit_mem;
        logic hit_wb;
        hit_mem = mem_valid && mem_write && (mem_reg == idx) && (idx != '0);
        hit_wb  = wb_write && (wb_reg == idx) && (idx != '0);
        if (hit_mem) begin
            return mem_data;
        end else if (hit_wb) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    always_comb begin
        rs_fwd = pick(rs_idx, rs_val);
        rt_fwd = pick(rt_idx, rt_val);
    end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module execute_stage import mips_pkg::*; (
    input  logic     ex_valid,
    input  logic     nullify,
    input  instr_t   instr,
    input  word_t    pcadd4,
    input  word_t    rs_fwd,
    input  word_t    rt_fwd,
    input  word_t    hi,
    input  word_t    lo,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    output logic     res_valid,
    output logic     res_write,
    output reg_idx_t res_dest,
    output word_t    res_data,
    output logic     res_taken,
    output word_t    res_pc_branch
);

    reg_idx_t rd_idx;
    imm_t     imm;
    shamt_t   shamt;
    alu_op_e  alu_op;
    src_b_e   src_b;
    res_src_e res_src;
    logic     var_shift;
    logic     writes;
    logic     dest_rd;
    logic     is_beq;
    logic     is_bne;
    word_t    imm_sext;
    word_t    imm_zext;
    word_t    alu_b;
    word_t    alu_y;
    shamt_t   alu_sa;
    logic     alu_zero;

    instr_decode u_decode (
        .instr    (instr),
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .rd_idx   (rd_idx),
        .imm      (imm),
        .shamt    (shamt),
        .alu_op   (alu_op),
        .src_b    (src_b),
        .res_src  (res_src),
        .var_shift(var_shift),
        .writes   (writes),
        .dest_rd  (dest_rd),
        .is_beq   (is_beq),
        .is_bne   (is_bne)
    );

    assign imm_sext = {{(`DATA_W-16){imm[15]}}, imm};
    assign imm_zext = {{(`DATA_W-16){1'b0}}, imm};

    always_comb begin
        case (src_b)
            SRC_B_SIGN: alu_b = imm_sext;
            SRC_B_ZERO: alu_b = imm_zext;
            default:    alu_b = rt_fwd;
        endcase
    end

    // variable shifts take the low bits of rs.
    assign alu_sa = var_shift ? rs_fwd[$bits(shamt_t)-1:0] : shamt;

    alu u_alu (
        .a   (rs_fwd),
        .b   (alu_b),
        .sa  (alu_sa),
        .op  (alu_op),
        .y   (alu_y),
        .zero(alu_zero)
    );

    always_comb begin
        case (res_src)
            RES_HI:  res_data = hi;
            RES_LO:  res_data = lo;
            default: res_data = alu_y;
        endcase
    end

    assign res_dest  = dest_rd ? rd_idx : rt_idx;
    assign res_valid = ex_valid && !nullify;
    assign res_write = res_valid && writes && (res_dest != '0);

    assign res_taken     = res_valid && ((is_beq && alu_zero) || (is_bne && !alu_zero));
    assign res_pc_branch = pcadd4 + {imm_sext[`DATA_W-3:0], 2'b00};

endmodule

// File: execute_top.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module execute_top import mips_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  instr_t   in_instr,
    input  word_t    in_pcadd4,
    input  word_t    in_rs_val,
    input  word_t    in_rt_val,
    input  word_t    hi,
    input  word_t    lo,
    input  logic     stall,
    input  logic     nullify,
    input  logic     wb_write,
    input  reg_idx_t wb_reg,
    input  word_t    wb_data,
    output logic     out_valid,
    output logic     out_write,
    output reg_idx_t out_dest_reg,
    output word_t    out_data,
    output logic     out_branch_taken,
    output word_t    out_pc_branch
);

    localparam int ID_EX_W  = $bits(instr_t) + 3 * `DATA_W;
    localparam int EX_MEM_W = 2 + `REG_W + 2 * `DATA_W;

    logic                ex_valid;
    logic [ID_EX_W-1:0]  id_ex_q;
    instr_t              ex_instr;
    word_t               ex_pcadd4;
    word_t               ex_rs_val;
    word_t               ex_rt_val;
    reg_idx_t            rs_idx;
    reg_idx_t            rt_idx;
    word_t               rs_fwd;
    word_t               rt_fwd;
    logic                res_valid;
    logic                res_write;
    reg_idx_t            res_dest;
    word_t               res_data;
    logic                res_taken;
    word_t               res_pc_branch;
    logic [EX_MEM_W-1:0] ex_mem_q;
    logic                mem_write;
    logic                mem_taken;

    pipe_reg #(.WIDTH(ID_EX_W)) u_id_ex (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .d_valid(in_valid),
        .d      ({in_instr, in_pcadd4, in_rs_val, in_rt_val}),
        .q_valid(ex_valid),
        .q      (id_ex_q)
    );

    assign {ex_instr, ex_pcadd4, ex_rs_val, ex_rt_val} = id_ex_q;

    forward_unit u_forward (
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .rs_val   (ex_rs_val),
        .rt_val   (ex_rt_val),
        .mem_valid(out_valid),
        .mem_write(out_write),
        .mem_reg  (out_dest_reg),
        .mem_data (out_data),
        .wb_write (wb_write),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .rs_fwd   (rs_fwd),
        .rt_fwd   (rt_fwd)
    );

    execute_stage u_execute (
        .ex_valid     (ex_valid),
        .nullify      (nullify),
        .instr        (ex_instr),
        .pcadd4       (ex_pcadd4),
        .rs_fwd       (rs_fwd),
        .rt_fwd       (rt_fwd),
        .hi           (hi),
        .lo           (lo),
        .rs_idx       (rs_idx),
        .rt_idx       (rt_idx),
        .res_valid    (res_valid),
        .res_write    (res_write),
        .res_dest     (res_dest),
        .res_data     (res_data),
        .res_taken    (res_taken),
        .res_pc_branch(res_pc_branch)
    );

    pipe_reg #(.WIDTH(EX_MEM_W)) u_ex_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .d_valid(res_valid),
        .d      ({res_write, res_dest, res_data, res_taken, res_pc_branch}),
        .q_valid(out_valid),
        .q      (ex_mem_q)
    );

    assign {mem_write, out_dest_reg, out_data, mem_taken, out_pc_branch} = ex_mem_q;

    // write and taken only count behind a valid entry.
    assign out_write        = out_valid && mem_write;
    assign out_branch_taken = out_valid && mem_taken;

endmodule

// File: execute_props.sv
`timescale 1ns/1ps

module execute_props import mips_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     stall,
    input logic     out_valid,
    input logic     out_write,
    input reg_idx_t out_dest_reg,
    input word_t    out_data,
    input logic     out_branch_taken,
    input word_t    out_pc_branch
);

    // outputs stay quiet while reset is held.
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid && !out_write)
        else $error("outputs active during reset");

    // a stalled edge leaves EX/MEM untouched.
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(out_valid) && $stable(out_write) && $stable(out_dest_reg)
                  && $stable(out_data) && $stable(out_branch_taken)
                  && $stable(out_pc_branch))
        else $error("EX/MEM changed during stall");

    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        out_write |-> out_dest_reg != '0)
        else $error("write to register 0");

endmodule

bind execute_top execute_props u_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .stall           (stall),
    .out_valid       (out_valid),
    .out_write       (out_write),
    .out_dest_reg    (out_dest_reg),
    .out_data        (out_data),
    .out_branch_taken(out_branch_taken),
    .out_pc_branch   (out_pc_branch)
);

// File: tb_execute.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module tb_execute import mips_pkg::*; ();

    localparam int TOTAL = 300 + 300 + 200 + 300 + 150;
    localparam int LIMIT = 4 * TOTAL + 200;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    instr_t   in_instr;
    word_t    in_pcadd4;
    word_t    in_rs_val;
    word_t    in_rt_val;
    word_t    hi;
    word_t    lo;
    logic     stall;
    logic     nullify;
    logic     wb_write;
    reg_idx_t wb_reg;
    word_t    wb_data;
    logic     out_valid;
    logic     out_write;
    reg_idx_t out_dest_reg;
    word_t    out_data;
    logic     out_branch_taken;
    word_t    out_pc_branch;

    // rf is the emulated register file, mreg the sequential reference.
    word_t    rf [0:31];
    word_t    mreg [0:31];
    logic     id_v, ex_v;
    instr_t   id_ins, ex_ins;
    word_t    id_pc, ex_pc, id_hi, ex_hi, id_lo, ex_lo;
    logic     p_write;
    reg_idx_t p_dest;
    word_t    p_data;
    int       issued;
    int       cycles;
    int       phase_checks, phase_errs, total_checks, total_errs;

    execute_top u_execute_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", LIMIT);
        $display("Regression failed");
        $finish;
    end

    function automatic logic [5:0] r_funct(input int idx);
        case (idx)
            0: return `FN_ADDU;
            1: return `FN_SUBU;
            2: return `FN_AND;
            3: return `FN_OR;
            4: return `FN_XOR;
            5: return `FN_NOR;
            6: return `FN_SLT;
            7: return `FN_SLTU;
            8: return `FN_SLL;
            9: return `FN_SRL;
            10: return `FN_SRA;
            11: return `FN_SLLV;
            12: return `FN_SRLV;
            default: return `FN_SRAV;
        endcase
    endfunction

    function automatic logic [5:0] i_opcode(input int idx);
        case (idx)
            14: return `OP_ADDIU;
            15: return `OP_ANDI;
            16: return `OP_ORI;
            17: return `OP_XORI;
            18: return `OP_SLTI;
            19: return `OP_SLTIU;
            20: return `OP_LUI;
            21: return `OP_BEQ;
            default: return `OP_BNE;
        endcase
    endfunction

    // kind 0 mixed, 1 alu only, 2 branch heavy, 3 hi/lo heavy.
    function automatic instr_t random_instr(input int kind);
        int          sel;
        logic [31:0] r;
        logic [15:0] imm;
        logic [4:0]  rs, rt, rd;
        r  = $urandom;
        rs = {2'b00, r[2:0]};
        rt = {2'b00, r[5:3]};
        rd = {2'b00, r[8:6]};
        imm = r[31:16];
        if (r[10:9] == 2'b00) begin
            case (r[12:11])
                2'd0: imm = 16'h8000;
                2'd1: imm = 16'h7fff;
                2'd2: imm = 16'hffff;
                default: imm = 16'h0000;
            endcase
        end
        case (kind)
            1: sel = int'($urandom % 21);
            2: sel = ($urandom % 2 == 0) ? 21 + int'($urandom % 2) : int'($urandom % 21);
            3: sel = ($urandom % 2 == 0) ? 23 + int'($urandom % 2) : int'($urandom % 21);
            default: sel = int'($urandom % 26);
        endcase
        if (sel < 14) begin
            return {`OP_SPECIAL, rs, rt, rd, r[13:9], r_funct(sel)};
        end else if (sel < 23) begin
            return {i_opcode(sel), rs, rt, imm};
        end else if (sel == 23) begin
            return {`OP_SPECIAL, 5'd0, 5'd0, rd, 5'd0, `FN_MFHI};
        end else if (sel == 24) begin
            return {`OP_SPECIAL, 5'd0, 5'd0, rd, 5'd0, `FN_MFLO};
        end
        return {6'h3f, rs, rt, imm};
    endfunction

    // sequential semantics of one instruction against mreg.
    task automatic ref_exec(input instr_t ins, input word_t pc4, input word_t hv,
                            input word_t lv, output logic w, output reg_idx_t dst,
                            output word_t dat, output logic tk, output word_t pcb,
                            output logic br);
        logic [5:0] op, fn;
        logic [4:0] sh;
        logic       ok;
        word_t      a, b, sx, zx;
        op  = ins[31:26];
        fn  = ins[5:0];
        sh  = ins[10:6];
        a   = mreg[ins[25:21]];
        b   = mreg[ins[20:16]];
        sx  = {{16{ins[15]}}, ins[15:0]};
        zx  = {16'h0000, ins[15:0]};
        dst = ins[20:16];
        dat = '0;
        ok  = 1'b1;
        br  = 1'b0;
        tk  = 1'b0;
        pcb = pc4 + (sx << 2);
        if (op == `OP_SPECIAL) begin
            dst = ins[15:11];
            case (fn)
                `FN_ADDU: dat = a + b;
                `FN_SUBU: dat = a - b;
                `FN_AND:  dat = a & b;
                `FN_OR:   dat = a | b;
                `FN_XOR:  dat = a ^ b;
                `FN_NOR:  dat = ~(a | b);
                `FN_SLT:  dat = {31'd0, $signed(a) < $signed(b)};
                `FN_SLTU: dat = {31'd0, a < b};
                `FN_SLL:  dat = b << sh;
                `FN_SRL:  dat = b >> sh;
                `FN_SRA:  dat = word_t'($signed(b) >>> sh);
                `FN_SLLV: dat = b << a[4:0];
                `FN_SRLV: dat = b >> a[4:0];
                `FN_SRAV: dat = word_t'($signed(b) >>> a[4:0]);
                `FN_MFHI: dat = hv;
                `FN_MFLO: dat = lv;
                default:  ok = 1'b0;
            endcase
        end else begin
            case (op)
                `OP_ADDIU: dat = a + sx;
                `OP_ANDI:  dat = a & zx;
                `OP_ORI:   dat = a | zx;
                `OP_XORI:  dat = a ^ zx;
                `OP_SLTI:  dat = {31'd0, $signed(a) < $signed(sx)};
                `OP_SLTIU: dat = {31'd0, a < sx};
                `OP_LUI:   dat = {ins[15:0], 16'h0000};
                `OP_BEQ: begin
                    br = 1'b1;
                    tk = (a == b);
                end
                `OP_BNE: begin
                    br = 1'b1;
                    tk = (a != b);
                end
                default: ok = 1'b0;
            endcase
        end
        w = ok && !br && (dst != 5'd0);
    endtask

    task automatic check_val(input string name, input word_t exp, input word_t got);
        phase_checks++;
        if (exp !== got) begin
            phase_errs++;
            $display("Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic step(input int kind, input int stall_pct, input int null_pct,
                        input bit issue);
        logic     w, tk, br;
        reg_idx_t dst;
        word_t    dat, pcb, r;
        @(negedge clk);
        if (!stall) begin
            // the entry that just left EX/MEM now sits in write-back.
            wb_write = p_write;
            wb_reg   = p_dest;
            wb_data  = p_data;
            if (p_write && p_dest != 5'd0) begin
                rf[p_dest] = p_data;
            end
            if (ex_v && !nullify) begin
                ref_exec(ex_ins, ex_pc, ex_hi, ex_lo, w, dst, dat, tk, pcb, br);
                if (w) begin
                    mreg[dst] = dat;
                end
                check_val("out_valid", 32'd1, {31'd0, out_valid});
                check_val("out_write", {31'd0, w}, {31'd0, out_write});
                if (w) begin
                    check_val("out_dest_reg", {27'd0, dst}, {27'd0, out_dest_reg});
                    check_val("out_data", dat, out_data);
                end
                check_val("out_branch_taken", {31'd0, tk}, {31'd0, out_branch_taken});
                if (br) begin
                    check_val("out_pc_branch", pcb, out_pc_branch);
                end
            end else begin
                check_val("out_valid", 32'd0, {31'd0, out_valid});
                check_val("out_write", 32'd0, {31'd0, out_write});
            end
            ex_v   = id_v;
            ex_ins = id_ins;
            ex_pc  = id_pc;
            ex_hi  = id_hi;
            ex_lo  = id_lo;
            id_v   = 1'b0;
            id_ins = '0;
            if (issue && ($urandom % 100) >= 10) begin
                r      = $urandom;
                id_v   = 1'b1;
                id_ins = random_instr(kind);
                id_pc  = {r[31:2], 2'b00};
                id_hi  = $urandom;
                id_lo  = $urandom;
                issued++;
            end
        end
        p_write   = out_write;
        p_dest    = out_dest_reg;
        p_data    = out_data;
        in_valid  = id_v;
        in_instr  = id_ins;
        in_pcadd4 = id_pc;
        in_rs_val = rf[id_ins[25:21]];
        in_rt_val = rf[id_ins[20:16]];
        hi        = ex_hi;
        lo        = ex_lo;
        stall     = ($urandom % 100) < stall_pct;
        nullify   = ($urandom % 100) < null_pct;
    endtask

    task automatic run_phase(input string name, input int kind, input int n,
                             input int stall_pct, input int null_pct);
        phase_checks = 0;
        phase_errs   = 0;
        issued       = 0;
        while (issued < n) begin
            step(kind, stall_pct, null_pct, 1'b1);
        end
        while (id_v || ex_v) begin
            step(kind, stall_pct, null_pct, 1'b0);
        end
        $display("%-14s checks %0d errors %0d", name, phase_checks, phase_errs);
        total_checks += phase_checks;
        total_errs   += phase_errs;
    endtask

    initial begin
        void'($urandom(78));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        in_pcadd4 = '0;
        in_rs_val = '0;
        in_rt_val = '0;
        hi        = '0;
        lo        = '0;
        stall     = 1'b0;
        nullify   = 1'b0;
        wb_write  = 1'b0;
        wb_reg    = '0;
        wb_data   = '0;
        id_v = 1'b0;
        ex_v = 1'b0;
        id_ins = '0;
        ex_ins = '0;
        id_pc = '0;
        ex_pc = '0;
        id_hi = '0;
        ex_hi = '0;
        id_lo = '0;
        ex_lo = '0;
        p_write = 1'b0;
        p_dest  = '0;
        p_data  = '0;
        total_checks = 0;
        total_errs   = 0;
        phase_checks = 0;
        phase_errs   = 0;
        for (int i = 0; i < 32; i++) begin
            rf[i]   = '0;
            mreg[i] = '0;
        end
        repeat (10) begin
            @(negedge clk);
            check_val("out_valid", 32'd0, {31'd0, out_valid});
            check_val("out_write", 32'd0, {31'd0, out_write});
        end
        rst_n = 1'b1;
        $display("%-14s checks %0d errors %0d", "reset", phase_checks, phase_errs);
        total_checks += phase_checks;
        total_errs   += phase_errs;

        run_phase("alu", 1, 300, 0, 0);
        run_phase("forwarding", 1, 300, 20, 0);
        run_phase("branches", 2, 200, 20, 10);
        run_phase("stall_nullify", 0, 300, 20, 10);
        run_phase("hi_lo", 3, 150, 20, 10);

        $display("Summary: %0d checks, %0d errors", total_checks, total_errs);
        if (total_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
mips_pkg.sv
alu.sv
instr_decode.sv
pipe_reg.sv
forward_unit.sv
execute_stage.sv
execute_top.sv
execute_props.sv
tb_execute.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= -sv --timing
TOP       ?= tb_execute
FLIST     ?= sim.f
PASS_MSG  := Regression passed
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST) | grep -v '^+')
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
